// File: Makefile
VERILATOR  ?= verilator
TOP        := lsu_tb
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/lsu_access_decode.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_access_decode import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  mem_op_e              req_op,
    input  lsu_addr_t            req_base,
    input  lsu_addr_t            req_offset,
    input  logic [`LSU_XLEN-1:0] req_wdata,
    lsu_access_if.decode         acc
);

    logic      accept;
    mem_size_e op_size;
    logic      op_sign;
    logic      op_store;
    logic [2:0] align_mask;

    // one access at a time, busy until the master is done
    assign req_ready = !acc.acc_valid;
    assign accept    = req_valid && req_ready;

    always_comb begin
        case (req_op)
            LB, LBU, SB: op_size = BYTE;
            LH, LHU, SH: op_size = HALF;
            LW, LWU, SW: op_size = WORD;
            default:     op_size = DOUBLE;
        endcase
    end

    // LD fills all lanes, so only the narrow loads extend
    assign op_sign  = req_op inside {LB, LH, LW};
    assign op_store = req_op inside {SB, SH, SW, SD};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc.acc_valid <= 1'b0;
        end else if (accept) begin
            acc.acc_valid <= 1'b1;
        end else if (acc.acc_done) begin
            acc.acc_valid <= 1'b0;
        end
    end

    // access fields, loaded once per request
    always_ff @(posedge clk) begin
        if (accept) begin
            acc.addr       <= req_base + req_offset;
            acc.size       <= op_size;
            acc.sign       <= op_sign;
            acc.is_store   <= op_store;
            acc.store_data <= req_wdata;
        end
    end

    // low address bits that must be zero for natural alignment
    always_comb begin
        case (acc.size)
            BYTE:    align_mask = 3'b000;
            HALF:    align_mask = 3'b001;
            WORD:    align_mask = 3'b011;
            default: align_mask = 3'b111;
        endcase
    end

    // natural alignment also keeps every access inside one doubleword
    assign acc.misaligned = |(acc.addr[2:0] & align_mask);

endmodule

// File: design/lsu_access_if.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

interface lsu_access_if import lsu_pkg::*; ();

    // held from acceptance until the edge after acc_done
    logic                 acc_valid;
    lsu_addr_t            addr;
    mem_size_e            size;
    logic                 sign;
    logic                 is_store;
    logic                 misaligned;
    // raw store operand, not yet placed in lanes
    logic [`LSU_XLEN-1:0] store_data;
    // single-cycle pulse, same cycle as resp_valid
    logic                 acc_done;

    modport decode (
        output acc_valid, addr, size, sign, is_store, misaligned, store_data,
        input  acc_done
    );

    // lanes only look at addr[2:0]
    modport lane (
        input addr, size, sign, store_data
    );

    modport master (
        input  acc_valid, addr, is_store, misaligned,
        output acc_done
    );

endinterface

// File: design/lsu_bus_master.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_bus_master import lsu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    lsu_access_if.master               acc,
    input  logic [`LSU_LANES-1:0]      lane_strb,
    input  logic [`LSU_LANES-1:0][7:0] lane_wdata,
    input  logic [`LSU_LANES-1:0][7:0] lane_ldata,
    output logic [`LSU_XLEN-1:0]       rdata_q,
    // read address and data
    output logic                       arvalid,
    input  logic                       arready,
    output lsu_addr_t                  araddr,
    input  logic                       rvalid,
    output logic                       rready,
    input  logic [`LSU_XLEN-1:0]       rdata,
    input  logic [1:0]                 rresp,
    // write address, data and response
    output logic                       awvalid,
    input  logic                       awready,
    output lsu_addr_t                  awaddr,
    output logic                       wvalid,
    input  logic                       wready,
    output logic [`LSU_XLEN-1:0]       wdata,
    output logic [`LSU_LANES-1:0]      wstrb,
    input  logic                       bvalid,
    output logic                       bready,
    input  logic [1:0]                 bresp,
    // response to the requester
    output logic                       resp_valid,
    output logic [`LSU_XLEN-1:0]       resp_data,
    output logic                       resp_err
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        R_WAIT,
        W_WAIT,
        B_WAIT,
        RESP
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic       launch;
    logic       rd_load;
    logic       wr_load;
    lsu_addr_t  beat_addr;
    lsu_wbeat_t wbeat_in;
    lsu_wbeat_t wbeat;
    logic       r_xfer;
    logic       aw_xfer;
    logic       w_xfer;
    logic       b_xfer;
    logic       aw_done_q;
    logic       w_done_q;
    logic       err_q;

    // misaligned accesses never reach the bus
    assign launch  = (state_q == ISSUE) && !acc.misaligned;
    assign rd_load = launch && !acc.is_store;
    assign wr_load = launch && acc.is_store;

    // bus works on whole doublewords, lanes pick the bytes
    assign beat_addr     = {acc.addr[`LSU_ADDR_W-1:3], 3'b000};
    assign wbeat_in.data = lane_wdata;
    assign wbeat_in.strb = lane_strb;

    lsu_chan_slot #(.payload_t(lsu_addr_t)) u_ar_slot (
        .clk          (clk),
        .rst          (rst),
        .load         (rd_load),
        .load_payload (beat_addr),
        .valid        (arvalid),
        .ready        (arready),
        .payload      (araddr)
    );

    lsu_chan_slot #(.payload_t(lsu_addr_t)) u_aw_slot (
        .clk          (clk),
        .rst          (rst),
        .load         (wr_load),
        .load_payload (beat_addr),
        .valid        (awvalid),
        .ready        (awready),
        .payload      (awaddr)
    );

    lsu_chan_slot #(.payload_t(lsu_wbeat_t)) u_w_slot (
        .clk          (clk),
        .rst          (rst),
        .load         (wr_load),
        .load_payload (wbeat_in),
        .valid        (wvalid),
        .ready        (wready),
        .payload      (wbeat)
    );

    assign wdata = wbeat.data;
    assign wstrb = wbeat.strb;

    assign r_xfer  = rvalid && rready;
    assign aw_xfer = awvalid && awready;
    assign w_xfer  = wvalid && wready;
    assign b_xfer  = bvalid && bready;

    // ready only in the state that waits for it
    assign rready = (state_q == R_WAIT);
    assign bready = (state_q == B_WAIT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (acc.acc_valid) state_d = ISSUE;
            end
            ISSUE: begin
                if (acc.misaligned) state_d = RESP;
                else if (acc.is_store) state_d = W_WAIT;
                else state_d = R_WAIT;
            end
            R_WAIT: begin
                if (r_xfer) state_d = RESP;
            end
            // AW and W may complete in either order
            W_WAIT: begin
                if ((aw_done_q || aw_xfer) && (w_done_q || w_xfer)) state_d = B_WAIT;
            end
            B_WAIT: begin
                if (b_xfer) state_d = RESP;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ISSUE) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
                err_q     <= acc.misaligned;
            end else begin
                if (aw_xfer) aw_done_q <= 1'b1;
                if (w_xfer) w_done_q <= 1'b1;
                // bus error is reported, not retried
                if (r_xfer) err_q <= (rresp != `LSU_RESP_OKAY);
                if (b_xfer) err_q <= (bresp != `LSU_RESP_OKAY);
            end
        end
    end

    // read beat, lanes extract from it
    always_ff @(posedge clk) begin
        if (r_xfer) begin
            rdata_q <= rdata;
        end
    end

    assign resp_valid   = (state_q == RESP);
    assign acc.acc_done = (state_q == RESP);
    assign resp_err     = err_q;
    // stores return zero data
    assign resp_data    = acc.is_store ? '0 : lane_ldata;

endmodule

// File: design/lsu_byte_lane.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_byte_lane import lsu_pkg::*; #(
    parameter int LANE = 0
) (
    lsu_access_if.lane           acc,
    input  logic [`LSU_XLEN-1:0] rdata_q,
    output logic                 strb,
    output logic [7:0]           wbyte,
    output logic [7:0]           lbyte
);

    localparam logic [3:0] LANE_IDX = 4'(LANE);

    logic [2:0] offset;
    logic [3:0] nbytes;
    logic [3:0] rel;
    logic       in_window;
    logic [2:0] src_lane;
    logic [2:0] top_lane;
    logic       fill_bit;

    assign offset = acc.addr[2:0];

    always_comb begin
        case (acc.size)
            BYTE:    nbytes = 4'd1;
            HALF:    nbytes = 4'd2;
            WORD:    nbytes = 4'd4;
            default: nbytes = 4'd8;
        endcase
    end

    // store side
    // position of this lane inside the access, bit 3 set when below the offset
    assign rel       = LANE_IDX - {1'b0, offset};
    assign in_window = !rel[3] && (rel < nbytes);

    assign strb  = in_window;
    assign wbyte = in_window ? acc.store_data[{rel[2:0], 3'b000} +: 8] : 8'h00;

    // load side
    // result byte LANE comes from bus lane offset + LANE
    assign src_lane = offset + LANE_IDX[2:0];
    // last bus lane of the access, wraps to 7 for a doubleword
    assign top_lane = offset + nbytes[2:0] - 3'd1;
    assign fill_bit = acc.sign & rdata_q[{top_lane, 3'b111}];

    // upper result bytes are the sign or zero fill
    assign lbyte = (LANE_IDX < nbytes) ? rdata_q[{src_lane, 3'b000} +: 8] : {8{fill_bit}};

endmodule

// File: design/lsu_chan_slot.sv
`timescale 1ns/1ps

module lsu_chan_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  payload_t load_payload,
    output logic     valid,
    input  logic     ready,
    output payload_t payload
);

    // valid holds until the slave takes the beat
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (valid && ready) begin
            valid <= 1'b0;
        end
    end

    // payload stays stable while valid is up
    always_ff @(posedge clk) begin
        if (load) begin
            payload <= load_payload;
        end
    end

endmodule

// File: design/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

    // loads come first, stores after
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        SB,
        SH,
        SW,
        SD
    } mem_op_e;

    // byte count is 1 << size
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } mem_size_e;

    typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;

    // one write beat, data already placed in its lanes
    typedef struct packed {
        logic [`LSU_XLEN-1:0]  data;
        logic [`LSU_LANES-1:0] strb;
    } lsu_wbeat_t;

endpackage

// File: design/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // request
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_op_e               req_op,
    input  lsu_addr_t             req_base,
    input  lsu_addr_t             req_offset,
    input  logic [`LSU_XLEN-1:0]  req_wdata,
    // response
    output logic                  resp_valid,
    output logic [`LSU_XLEN-1:0]  resp_data,
    output logic                  resp_err,
    // read channels
    output logic                  arvalid,
    input  logic                  arready,
    output lsu_addr_t             araddr,
    input  logic                  rvalid,
    output logic                  rready,
    input  logic [`LSU_XLEN-1:0]  rdata,
    input  logic [1:0]            rresp,
    // write channels
    output logic                  awvalid,
    input  logic                  awready,
    output lsu_addr_t             awaddr,
    output logic                  wvalid,
    input  logic                  wready,
    output logic [`LSU_XLEN-1:0]  wdata,
    output logic [`LSU_LANES-1:0] wstrb,
    input  logic                  bvalid,
    output logic                  bready,
    input  logic [1:0]            bresp
);

    lsu_access_if acc ();

    // per-lane results, one entry per byte lane
    logic [`LSU_LANES-1:0]      lane_strb;
    logic [`LSU_LANES-1:0][7:0] lane_wdata;
    logic [`LSU_LANES-1:0][7:0] lane_ldata;
    logic [`LSU_XLEN-1:0]       rdata_q;

    lsu_access_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .acc        (acc)
    );

    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
        lsu_byte_lane #(.LANE(i)) u_lane (
            .acc     (acc),
            .rdata_q (rdata_q),
            .strb    (lane_strb[i]),
            .wbyte   (lane_wdata[i]),
            .lbyte   (lane_ldata[i])
        );
    end

    lsu_bus_master u_master (
        .clk        (clk),
        .rst        (rst),
        .acc        (acc),
        .lane_strb  (lane_strb),
        .lane_wdata (lane_wdata),
        .lane_ldata (lane_ldata),
        .rdata_q    (rdata_q),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_err   (resp_err)
    );

endmodule

// File: dv/lsu_mem_slave.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_mem_slave import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  arvalid,
    output logic                  arready,
    input  lsu_addr_t             araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [`LSU_XLEN-1:0]  rdata,
    output logic [1:0]            rresp,
    input  logic                  awvalid,
    output logic                  awready,
    input  lsu_addr_t             awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [`LSU_XLEN-1:0]  wdata,
    input  logic [`LSU_LANES-1:0] wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp
);

    logic [7:0] mem [0:255];
    int         seed;
    // transfers seen per address channel
    int         ar_count;
    int         aw_count;

    // 0 to 4 cycles
    function automatic int delay();
        return $unsigned($random(seed)) % 5;
    endfunction

    // top 16 bytes are the error region
    function automatic logic [1:0] resp_for(lsu_addr_t a);
        return (a[7:0] >= 8'hF0) ? 2'b10 : `LSU_RESP_OKAY;
    endfunction

    initial begin
        seed     = 14747;
        ar_count = 0;
        aw_count = 0;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        rresp    = `LSU_RESP_OKAY;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        bresp    = `LSU_RESP_OKAY;
        // fill depends on the whole address and matches the shadow copy
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 37 + 90);
        end
    end

    // read side handles one beat at a time
    always begin : read_chan
        lsu_addr_t a;
        int        d;
        logic      taken;
        @(posedge clk);
        #1;
        if (!rst && arvalid) begin
            d = delay();
            repeat (d) begin
                @(posedge clk);
                #1;
            end
            arready = 1'b1;
            a = araddr;
            @(posedge clk);
            #1;
            arready = 1'b0;
            ar_count++;
            d = delay();
            repeat (d) begin
                @(posedge clk);
                #1;
            end
            for (int i = 0; i < 8; i++) begin
                rdata[8*i +: 8] = mem[{a[7:3], 3'(i)}];
            end
            rresp  = resp_for(a);
            rvalid = 1'b1;
            taken  = 1'b0;
            // rready is steady between edges
            while (!taken) begin
                taken = rready;
                @(posedge clk);
                #1;
            end
            rvalid = 1'b0;
        end
    end

    // write side takes AW first and then W
    always begin : write_chan
        lsu_addr_t                  a;
        logic [`LSU_XLEN-1:0]       wd;
        logic [`LSU_LANES-1:0]      ws;
        int                         d;
        logic                       taken;
        @(posedge clk);
        #1;
        if (!rst && awvalid) begin
            d = delay();
            repeat (d) begin
                @(posedge clk);
                #1;
            end
            awready = 1'b1;
            a = awaddr;
            @(posedge clk);
            #1;
            awready = 1'b0;
            aw_count++;
            d = delay();
            repeat (d) begin
                @(posedge clk);
                #1;
            end
            // a beat is taken only while it is offered
            while (!wvalid) begin
                @(posedge clk);
                #1;
            end
            wready = 1'b1;
            wd = wdata;
            ws = wstrb;
            @(posedge clk);
            #1;
            wready = 1'b0;
            // error region keeps its contents
            if (a[7:0] < 8'hF0) begin
                for (int i = 0; i < 8; i++) begin
                    if (ws[i]) mem[{a[7:3], 3'(i)}] = wd[8*i +: 8];
                end
            end
            d = delay();
            repeat (d) begin
                @(posedge clk);
                #1;
            end
            bresp  = resp_for(a);
            bvalid = 1'b1;
            taken  = 1'b0;
            while (!taken) begin
                taken = bready;
                @(posedge clk);
                #1;
            end
            bvalid = 1'b0;
        end
    end

endmodule

// File: dv/lsu_sva.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_sva import lsu_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  arvalid,
    input logic                  arready,
    input lsu_addr_t             araddr,
    input logic                  awvalid,
    input logic                  awready,
    input lsu_addr_t             awaddr,
    input logic                  wvalid,
    input logic                  wready,
    input logic [`LSU_XLEN-1:0]  wdata,
    input logic [`LSU_LANES-1:0] wstrb,
    input logic                  resp_valid
);

    // valid and payload hold until the transfer
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR valid or address changed before transfer");

    aw_stable: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW valid or address changed before transfer");

    w_stable: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("W valid or beat changed before transfer");

    // single cycle response
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else $error("response valid held for more than one cycle");

    // a load never opens the write side, and the other way round
    one_dir: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && (awvalid || wvalid)))
        else $error("read and write address channels active in one access");

endmodule

// File: dv/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int N_RAND  = 40;
    // random pairs plus the directed accesses
    localparam int NUM_REQ = 2 * N_RAND + 16;
    localparam int LIMIT   = NUM_REQ * 40;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic                  req_ready;
    mem_op_e               req_op;
    lsu_addr_t             req_base;
    lsu_addr_t             req_offset;
    logic [`LSU_XLEN-1:0]  req_wdata;
    logic                  resp_valid;
    logic [`LSU_XLEN-1:0]  resp_data;
    logic                  resp_err;
    logic                  arvalid;
    logic                  arready;
    logic                  rvalid;
    logic                  rready;
    logic                  awvalid;
    logic                  awready;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    lsu_addr_t             araddr;
    lsu_addr_t             awaddr;
    logic [`LSU_XLEN-1:0]  rdata;
    logic [`LSU_XLEN-1:0]  wdata;
    logic [`LSU_LANES-1:0] wstrb;
    logic [1:0]            rresp;
    logic [1:0]            bresp;

    logic [7:0]            shadow [0:255];
    int                    seed;
    int                    cycles;
    int                    resp_count;
    logic                  busy;
    // expectation for the access in flight
    logic [`LSU_XLEN-1:0]  exp_data;
    logic                  exp_err;
    logic                  exp_chk;
    logic [`LSU_XLEN-1:0]  last_data;

    lsu_top dut (.*);

    lsu_mem_slave u_slave (.*);

    bind lsu_bus_master lsu_sva u_sva (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .wvalid(wvalid),
        .wready(wready), .wdata(wdata), .wstrb(wstrb), .resp_valid(resp_valid)
    );

    always #5 clk = ~clk;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    // single control bit against its expected level
    task automatic check_bit(string name, logic got, logic exp);
        assert (got == exp) else
            fail_run($sformatf("ERR t=%0t %s got %b exp %b", $time, name, got, exp));
    endtask

    function automatic int rnd(int m);
        return $unsigned($random(seed)) % m;
    endfunction

    function automatic int op_bytes(mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    // expected load from little endian bytes
    // narrow signed loads extend the top bit of the access
    function automatic logic [`LSU_XLEN-1:0] load_ref(mem_op_e op, lsu_addr_t addr);
        logic [`LSU_XLEN-1:0] v;
        int                   n;
        logic                 fill;
        n    = op_bytes(op);
        fill = (op inside {LB, LH, LW}) && shadow[int'(addr[7:0]) + n - 1][7];
        for (int i = 0; i < 8; i++) begin
            if (i < n) v[8*i +: 8] = shadow[int'(addr[7:0]) + i];
            else v[8*i +: 8] = {8{fill}};
        end
        return v;
    endfunction

    // issues one request and waits for its response
    task automatic access(mem_op_e op, lsu_addr_t base, lsu_addr_t offset,
                          logic [`LSU_XLEN-1:0] wd);
        lsu_addr_t addr;
        int        n;
        int        target;
        logic      mis;
        logic      is_st;
        addr  = base + offset;
        n     = op_bytes(op);
        mis   = (int'(addr[2:0]) % n) != 0;
        is_st = op inside {SB, SH, SW, SD};
        exp_err = mis || (addr[7:0] >= 8'hF0);
        if (is_st) begin
            exp_chk  = 1'b1;
            exp_data = '0;
            if (!exp_err) begin
                for (int i = 0; i < n; i++) shadow[int'(addr[7:0]) + i] = wd[8*i +: 8];
            end
        end else begin
            exp_chk  = !exp_err;
            exp_data = exp_err ? '0 : load_ref(op, addr);
        end
        target = resp_count + 1;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        req_valid  = 1'b1;
        req_op     = op;
        req_base   = base;
        req_offset = offset;
        req_wdata  = wd;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        while (resp_count < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    // signed and unsigned loads of the same bytes
    task automatic check_ext(mem_op_e s_op, mem_op_e u_op, lsu_addr_t a);
        logic [`LSU_XLEN-1:0] s_val;
        logic [`LSU_XLEN-1:0] u_val;
        logic [`LSU_XLEN-1:0] low_mask;
        low_mask = (64'd1 << (8 * op_bytes(s_op))) - 64'd1;
        access(s_op, a, 32'd0, '0);
        s_val = last_data;
        access(u_op, a, 32'd0, '0);
        u_val = last_data;
        assert ((u_val & ~low_mask) == '0 && s_val == (u_val | ~low_mask)) else
            fail_run($sformatf("ERR t=%0t resp_data signed %h unsigned %h", $time,
                               s_val, u_val));
    endtask

    // check each response at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (busy) begin
                check_bit("req_ready", req_ready, 1'b0);
            end
            if (resp_valid) begin
                assert (resp_err == exp_err) else
                    fail_run($sformatf("ERR t=%0t resp_err got %b exp %b", $time,
                                       resp_err, exp_err));
                if (exp_chk) begin
                    assert (resp_data == exp_data) else
                        fail_run($sformatf("ERR t=%0t resp_data got %h exp %h", $time,
                                           resp_data, exp_data));
                end
                last_data = resp_data;
                resp_count++;
                busy = 1'b0;
            end
            if (req_valid && req_ready) busy = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles without finishing", LIMIT));
        end
    end

    initial begin : stimulus
        mem_op_e   st;
        mem_op_e   ld;
        lsu_addr_t base;
        int        ar0;
        int        aw0;
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_op     = LB;
        req_base   = '0;
        req_offset = '0;
        req_wdata  = '0;
        seed       = 14747;
        cycles     = 0;
        resp_count = 0;
        busy       = 1'b0;
        exp_data   = '0;
        exp_err    = 1'b0;
        exp_chk    = 1'b0;
        last_data  = '0;
        for (int i = 0; i < 256; i++) shadow[i] = 8'(i * 37 + 90);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle levels straight out of reset
        check_bit("req_ready", req_ready, 1'b1);
        check_bit("resp_valid", resp_valid, 1'b0);
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("awvalid", awvalid, 1'b0);
        check_bit("wvalid", wvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
        check_bit("bready", bready, 1'b0);

        // random stores then loads below the error region
        for (int k = 0; k < N_RAND; k++) begin
            st   = mem_op_e'(4'(7 + rnd(4)));
            ld   = mem_op_e'(4'(rnd(7)));
            base = 32'(rnd(30) * 8);
            access(st, base, 32'(rnd(8 / op_bytes(st)) * op_bytes(st)),
                   {32'($random(seed)), 32'($random(seed))});
            access(ld, base, 32'(rnd(8 / op_bytes(ld)) * op_bytes(ld)), '0);
        end

        // strobes touch only the addressed bytes
        access(LD, 32'h20, 32'd0, '0);
        access(SB, 32'h20, 32'd3, 64'h1111_2222_3333_44C5);
        access(LD, 32'h20, 32'd0, '0);
        access(SH, 32'h20, 32'd6, 64'h5555_6666_7777_D8E9);
        access(LD, 32'h20, 32'd0, '0);

        // high bit set at the top of each size
        access(SD, 32'h40, 32'd0, 64'hC3D4_E5F6_B7A8_9A81);
        check_ext(LB, LBU, 32'h40);
        check_ext(LH, LHU, 32'h40);
        check_ext(LW, LWU, 32'h40);

        // misaligned accesses never reach the bus
        ar0 = u_slave.ar_count;
        aw0 = u_slave.aw_count;
        access(LH, 32'h40, 32'd1, '0);
        access(SW, 32'h40, 32'd2, 64'hDEAD_BEEF_0123_4567);
        assert (u_slave.ar_count == ar0 && u_slave.aw_count == aw0) else
            fail_run("a misaligned access reached the bus");

        // error region
        access(LD, 32'hF0, 32'd0, '0);
        access(SD, 32'hE0, 32'h18, 64'h0F0F_0F0F_0F0F_0F0F);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: include/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data path width, one doubleword per beat
`define LSU_XLEN 64

// byte address on the bus
`define LSU_ADDR_W 32

// one lane per data byte
`define LSU_LANES 8

// bus response code for success
`define LSU_RESP_OKAY 2'b00

`endif

// File: vlog.f
+incdir+include
design/lsu_pkg.sv
design/lsu_access_if.sv
design/lsu_access_decode.sv
design/lsu_byte_lane.sv
design/lsu_chan_slot.sv
design/lsu_bus_master.sv
design/lsu_top.sv
dv/lsu_mem_slave.sv
dv/lsu_sva.sv
dv/lsu_tb.sv
